// File: hdl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// first fetch address after reset
`define RESET_PC    32'h0000_0000

// bus credits, the counter saturates at MEM_CREDITS
`define MEM_CREDITS 2
`define CREDIT_W    2

`endif

// File: hdl/cpu_pkg.sv
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0] word_t;

    // rv32i major opcodes, subset only
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        PASS_B, // lui immediate
        EQ,
        NE,
        LTU,
        GEU
    } alu_op_e;

    typedef enum logic [2:0] {
        FETCH_REQ,
        FETCH_WAIT,
        EXECUTE,
        MEM_REQ,
        MEM_WAIT,
        WRITEBACK,
        HALTED
    } seq_state_e;

endpackage

`default_nettype wire

// File: hdl/mem_request.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_params.svh"

module mem_request import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  credit_i,
    input  logic  issue_fetch_i,
    input  logic  issue_data_i,
    input  logic  data_write_i,
    input  word_t pc_i,
    input  word_t data_addr_i,
    input  word_t store_data_i,
    output logic  req_sent_o,
    output logic  req_valid_o,
    output logic  req_write_o,
    output word_t req_addr_o,
    output word_t req_wdata_o
);

    logic [`CREDIT_W-1:0] credit_cnt;
    logic                 pending_q; // request latched, waiting for a credit
    logic                 fire;

    // a credit arriving this cycle can be spent right away
    assign fire = (issue_fetch_i | issue_data_i | pending_q) & ((credit_cnt != '0) | credit_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt  <= '0;
            pending_q   <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= fire; // one cycle per request
            if (fire) begin
                pending_q <= 1'b0;
            end else if (issue_fetch_i | issue_data_i) begin
                pending_q <= 1'b1;
            end
            case ({credit_i, fire})
                2'b10: if (credit_cnt != `CREDIT_W'(`MEM_CREDITS)) credit_cnt <= credit_cnt + 1'b1;
                2'b01: credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt; // 11 spends the new credit
            endcase
        end
    end

    // request payload, captured when the sequencer asks
    always_ff @(posedge clk) begin
        if (issue_fetch_i) begin
            req_addr_o  <= pc_i;
            req_write_o <= 1'b0;
            req_wdata_o <= '0;
        end else if (issue_data_i) begin
            req_addr_o  <= data_addr_i;
            req_write_o <= data_write_i;
            req_wdata_o <= store_data_i;
        end
    end

    assign req_sent_o = req_valid_o;

endmodule

`default_nettype wire

// File: hdl/mem_response.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_params.svh"

module mem_response import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rsp_valid_i,
    input  logic  fetching_i,
    input  word_t rsp_rdata_i,
    output logic  rsp_done_o,
    output word_t instr_o,
    output word_t load_data_o
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_o     <= '0;
            load_data_o <= '0;
        end else if (rsp_valid_i) begin
            // one outstanding request, so the phase tells which word this is
            if (fetching_i) begin
                instr_o <= rsp_rdata_i;
            end else begin
                load_data_o <= rsp_rdata_i; // store acks land here too
            end
        end
    end

    // responses are never stalled
    assign rsp_done_o = rsp_valid_i;

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_params.svh"

module instr_decoder import cpu_pkg::*; (
    input  word_t                  instr_i,
    output opcode_e                opcode_o,
    output alu_op_e                alu_op_o,
    output logic [`REG_ADDR_W-1:0] rs1_o,
    output logic [`REG_ADDR_W-1:0] rs2_o,
    output logic [`REG_ADDR_W-1:0] rd_o,
    output word_t                  imm_o,
    output logic                   use_imm_o,
    output logic                   legal_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_j, imm_u;

    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // register fields sit at fixed positions in every format
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    assign opcode_o = opcode_e'(instr_i[6:0]);

    always_comb begin
        alu_op_o  = ADD;
        imm_o     = imm_i;
        use_imm_o = 1'b1;
        legal_o   = 1'b1;
        case (opcode_o)
            OP, OP_IMM: begin
                use_imm_o = (opcode_o == OP_IMM);
                case (funct3)
                    3'b000: begin
                        // no subi, funct7 only counts for the register form
                        if (opcode_o == OP && funct7 == 7'b0100000) alu_op_o = SUB;
                        else if (opcode_o == OP && funct7 != 7'b0) legal_o = 1'b0;
                    end
                    3'b100: alu_op_o = XOR;
                    3'b110: alu_op_o = OR;
                    3'b111: alu_op_o = AND;
                    3'b001: begin
                        alu_op_o = SLL;
                        legal_o  = (funct7 == 7'b0);
                    end
                    3'b101: begin
                        alu_op_o = SRL;
                        legal_o  = (funct7 == 7'b0); // no arithmetic shift
                    end
                    default: legal_o = 1'b0; // slt, sltu
                endcase
            end
            LOAD:  legal_o = (funct3 == 3'b010); // words only
            STORE: begin
                imm_o   = imm_s;
                legal_o = (funct3 == 3'b010);
            end
            BRANCH: begin
                imm_o     = imm_b;
                use_imm_o = 1'b0; // compare rs1 with rs2
                case (funct3)
                    3'b000:  alu_op_o = EQ;
                    3'b001:  alu_op_o = NE;
                    3'b100:  alu_op_o = LTU; // blt, unsigned here
                    3'b101:  alu_op_o = GEU;
                    default: legal_o = 1'b0;
                endcase
            end
            JAL: imm_o = imm_j;
            LUI: begin
                imm_o    = imm_u;
                alu_op_o = PASS_B;
            end
            default: legal_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_params.svh"

module alu import cpu_pkg::*; (
    input  alu_op_e alu_op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o,
    output logic    cond_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0]; // upper bits of the amount are ignored

    always_comb begin
        result_o = '0;
        cond_o   = 1'b0;
        case (alu_op_i)
            ADD:    result_o = a_i + b_i;
            SUB:    result_o = a_i - b_i;
            XOR:    result_o = a_i ^ b_i;
            OR:     result_o = a_i | b_i;
            AND:    result_o = a_i & b_i;
            SLL:    result_o = a_i << shamt;
            SRL:    result_o = a_i >> shamt;
            PASS_B: result_o = b_i;
            // branch compares are all unsigned
            EQ: cond_o = (a_i == b_i);
            NE: cond_o = (a_i != b_i);
            LTU: cond_o = (a_i < b_i);
            GEU: cond_o = (a_i >= b_i);
            default: begin
                result_o = '0;
                cond_o   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`default_nettype none
`timescale 1ns/100ps

module register_file import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       we_i,
    input  logic [4:0] rs1_i,
    input  logic [4:0] rs2_i,
    input  logic [4:0] rd_i,
    input  word_t      wdata_i,
    output word_t      rs1_data_o,
    output word_t      rs2_data_o
);

    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i; // x0 never written
        end
    end

    // combinational read, no bypass needed in a multi-cycle core
    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

`default_nettype wire

// File: hdl/core_sequencer.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_params.svh"

module core_sequencer import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    req_sent_i,
    input  logic    rsp_done_i,
    input  logic    legal_i,
    input  logic    cond_i,
    input  opcode_e opcode_i,
    input  word_t   imm_i,
    input  word_t   alu_result_i,
    input  word_t   load_data_i,
    output logic    issue_fetch_o,
    output logic    issue_data_o,
    output logic    data_write_o,
    output logic    fetching_o,
    output logic    reg_we_o,
    output logic    halted_o,
    output word_t   pc_o,
    output word_t   wdata_o
);

    seq_state_e state, next_state;
    logic       issued_q; // request handed to the bus port
    word_t      pc_plus4, pc_target;
    logic       take_target;
    logic       writes_rd;

    assign pc_plus4    = pc_o + 32'd4;
    assign pc_target   = pc_o + imm_i;
    assign take_target = (opcode_i == JAL) || (opcode_i == BRANCH && cond_i);
    assign writes_rd   = (opcode_i == OP) || (opcode_i == OP_IMM) ||
                         (opcode_i == LUI) || (opcode_i == JAL);

    // request pulses, one per bus phase
    assign issue_fetch_o = (state == FETCH_REQ) && !issued_q;
    assign issue_data_o  = (state == MEM_REQ) && !issued_q;
    assign data_write_o  = (opcode_i == STORE);
    assign fetching_o    = (state == FETCH_REQ) || (state == FETCH_WAIT);
    assign halted_o      = (state == HALTED);

    assign reg_we_o = (state == EXECUTE && legal_i && writes_rd) || (state == WRITEBACK);
    assign wdata_o  = (state == WRITEBACK) ? load_data_i :
                      (opcode_i == JAL)    ? pc_plus4    : alu_result_i;

    always_comb begin
        next_state = state;
        case (state)
            FETCH_REQ:  if (req_sent_i) next_state = FETCH_WAIT;
            FETCH_WAIT: if (rsp_done_i) next_state = EXECUTE;
            EXECUTE: begin
                if (!legal_i) next_state = HALTED;
                else if (opcode_i == LOAD || opcode_i == STORE) next_state = MEM_REQ;
                else next_state = FETCH_REQ;
            end
            MEM_REQ:  if (req_sent_i) next_state = MEM_WAIT;
            MEM_WAIT: begin
                if (rsp_done_i) next_state = (opcode_i == LOAD) ? WRITEBACK : FETCH_REQ;
            end
            WRITEBACK: next_state = FETCH_REQ;
            HALTED:    next_state = HALTED; // only reset leaves
            default:   next_state = HALTED;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= FETCH_REQ;
            issued_q <= 1'b0;
            pc_o     <= `RESET_PC;
        end else begin
            state <= next_state;
            if (req_sent_i) begin
                issued_q <= 1'b0;
            end else if (issue_fetch_o || issue_data_o) begin
                issued_q <= 1'b1;
            end
            // data address comes from the ALU, so pc can move early
            if (state == EXECUTE && legal_i) begin
                pc_o <= take_target ? pc_target : pc_plus4;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  credit_i,
    input  logic  rsp_valid_i,
    input  word_t rsp_rdata_i,
    output logic  req_valid_o,
    output logic  req_write_o,
    output logic  halted_o,
    output word_t req_addr_o,
    output word_t req_wdata_o
);

    logic                   req_sent, rsp_done, issue_fetch, issue_data, data_write;
    logic                   fetching, reg_we, use_imm, legal, cond;
    opcode_e                opcode;
    alu_op_e                alu_op;
    logic [`REG_ADDR_W-1:0] rs1, rs2, rd;
    word_t                  pc, instr, load_data, imm, rs1_data, rs2_data;
    word_t                  alu_b, alu_result, wdata;

    assign alu_b = use_imm ? imm : rs2_data; // operand select

    mem_request u_mem_request (
        .clk(clk), .rst(rst), .credit_i(credit_i),
        .issue_fetch_i(issue_fetch), .issue_data_i(issue_data), .data_write_i(data_write),
        .pc_i(pc), .data_addr_i(alu_result), .store_data_i(rs2_data),
        .req_sent_o(req_sent), .req_valid_o(req_valid_o), .req_write_o(req_write_o),
        .req_addr_o(req_addr_o), .req_wdata_o(req_wdata_o)
    );

    mem_response u_mem_response (
        .clk(clk), .rst(rst), .rsp_valid_i(rsp_valid_i), .fetching_i(fetching),
        .rsp_rdata_i(rsp_rdata_i), .rsp_done_o(rsp_done),
        .instr_o(instr), .load_data_o(load_data)
    );

    core_sequencer u_core_sequencer (
        .clk(clk), .rst(rst), .req_sent_i(req_sent), .rsp_done_i(rsp_done),
        .legal_i(legal), .cond_i(cond), .opcode_i(opcode), .imm_i(imm),
        .alu_result_i(alu_result), .load_data_i(load_data),
        .issue_fetch_o(issue_fetch), .issue_data_o(issue_data), .data_write_o(data_write),
        .fetching_o(fetching), .reg_we_o(reg_we), .halted_o(halted_o),
        .pc_o(pc), .wdata_o(wdata)
    );

    instr_decoder u_instr_decoder (
        .instr_i(instr), .opcode_o(opcode), .alu_op_o(alu_op),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
        .use_imm_o(use_imm), .legal_o(legal)
    );

    alu u_alu (
        .alu_op_i(alu_op), .a_i(rs1_data), .b_i(alu_b),
        .result_o(alu_result), .cond_o(cond)
    );

    register_file u_register_file (
        .clk(clk), .rst(rst), .we_i(reg_we),
        .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .wdata_i(wdata),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// x1 = 5 and x2 = -3 feed most of the checks below
localparam int STORE_COUNT = 20;

// expected store data for consecutive words from 0x100 upward
localparam word_t exp_data [STORE_COUNT] = '{
    32'h0000_0002, 32'h0000_0008, 32'hffff_fff8, 32'hffff_fffd, 32'h0000_0005,
    32'h0000_0028, 32'h1fff_ffff, 32'hffff_fffa, 32'h0000_00f5, 32'h0000_07f0,
    32'h0000_0050, 32'h0000_000f, 32'habcd_e123, 32'habcd_e123, 32'h0000_0000,
    32'h0000_0005, 32'h0000_0002, 32'h0000_0008, 32'h0000_0005, 32'h0000_00cc
};

// instructions that are jumped over and never fetched
localparam word_t skip_pc [6] = '{32'd140, 32'd156, 32'd172, 32'd188, 32'd204, 32'd208};

task automatic load_program();
    for (int i = 0; i < 256; i++) begin
        mem[i] = 32'h5a5a_0000 ^ 32'(i << 2);
    end
    mem[0]  = alu_ri(0, 1, 0, 5);           // addi x1, x0, 5
    mem[1]  = alu_ri(0, 2, 0, -3);
    mem[2]  = alu_rr('h00, 0, 3, 1, 2);     // add
    mem[3]  = store_w(3, 0, 32'h100);
    mem[4]  = alu_rr('h20, 0, 4, 1, 2);     // sub
    mem[5]  = store_w(4, 0, 32'h104);
    mem[6]  = alu_rr('h00, 4, 5, 1, 2);     // xor
    mem[7]  = store_w(5, 0, 32'h108);
    mem[8]  = alu_rr('h00, 6, 6, 1, 2);     // or
    mem[9]  = alu_rr('h00, 7, 7, 1, 2);     // and
    mem[10] = store_w(6, 0, 32'h10c);
    mem[11] = store_w(7, 0, 32'h110);
    mem[12] = alu_ri(0, 8, 0, 35);          // shift amount 35 masks to 3
    mem[13] = alu_rr('h00, 1, 9, 1, 8);     // sll
    mem[14] = alu_rr('h00, 5, 10, 2, 8);    // srl
    mem[15] = store_w(9, 0, 32'h114);
    mem[16] = store_w(10, 0, 32'h118);
    mem[17] = alu_ri(4, 11, 1, -1);         // xori
    mem[18] = alu_ri(6, 12, 1, 32'h0f0);
    mem[19] = alu_ri(7, 13, 2, 32'h7f0);
    mem[20] = alu_ri(1, 14, 1, 4);          // slli
    mem[21] = alu_ri(5, 15, 2, 28);         // srli
    mem[22] = store_w(11, 0, 32'h11c);
    mem[23] = store_w(12, 0, 32'h120);
    mem[24] = store_w(13, 0, 32'h124);
    mem[25] = store_w(14, 0, 32'h128);
    mem[26] = store_w(15, 0, 32'h12c);
    mem[27] = lui_to(16, 32'habcde);
    mem[28] = alu_ri(0, 16, 16, 32'h123);
    mem[29] = store_w(16, 0, 32'h130);
    mem[30] = load_w(17, 0, 32'h130);
    mem[31] = store_w(17, 0, 32'h134);
    mem[32] = alu_ri(0, 0, 0, 7);           // write to x0 is dropped
    mem[33] = store_w(0, 0, 32'h138);
    mem[34] = branch(0, 1, 1, 8);           // beq taken
    mem[35] = store_w(1, 0, 32'h1f0);
    mem[36] = branch(0, 1, 2, 8);
    mem[37] = store_w(1, 0, 32'h13c);
    mem[38] = branch(1, 1, 2, 8);           // bne taken
    mem[39] = store_w(1, 0, 32'h1f0);
    mem[40] = branch(1, 1, 1, 8);
    mem[41] = store_w(3, 0, 32'h140);
    mem[42] = branch(4, 1, 2, 8);           // blt taken as 5 is below 0xfffffffd unsigned
    mem[43] = store_w(1, 0, 32'h1f0);
    mem[44] = branch(4, 2, 1, 8);
    mem[45] = store_w(4, 0, 32'h144);
    mem[46] = branch(5, 2, 1, 8);           // bge taken
    mem[47] = store_w(1, 0, 32'h1f0);
    mem[48] = branch(5, 1, 2, 8);
    mem[49] = store_w(7, 0, 32'h148);
    mem[50] = jal_to(18, 12);               // link is 204
    mem[51] = store_w(1, 0, 32'h1f0);
    mem[52] = store_w(1, 0, 32'h1f0);
    mem[53] = store_w(18, 0, 32'h14c);
    mem[54] = 32'h0000_0000;                // illegal word halts the core
endtask

`endif

// File: tb/tb_cpu_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "cpu_params.svh"

module tb_cpu_top import cpu_pkg::*; ();

    logic  clk = 1'b0;
    logic  rst;
    logic  credit_i;
    logic  rsp_valid_i;
    word_t rsp_rdata_i;
    logic  req_valid_o;
    logic  req_write_o;
    logic  halted_o;
    word_t req_addr_o;
    word_t req_wdata_o;

    word_t mem [0:255]; // 1 KB, word addressed
    int    cycles, since_reset, errors, err_mark, tests_run, tests_failed;
    int    sent, credits_given, outstanding, store_idx, credit_gap, rsp_delay;
    logic  rsp_pend, first_req_seen;
    word_t rsp_data;

    cpu_top UUT (
        .clk(clk), .rst(rst), .credit_i(credit_i), .rsp_valid_i(rsp_valid_i),
        .rsp_rdata_i(rsp_rdata_i), .req_valid_o(req_valid_o), .req_write_o(req_write_o),
        .halted_o(halted_o), .req_addr_o(req_addr_o), .req_wdata_o(req_wdata_o)
    );

    always #50 clk = ~clk;

    // instruction encoders for the rv32i formats
    function automatic word_t alu_rr(input int f7, input int f3, input int rd, input int rs1,
                                     input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t alu_ri(input int f3, input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t load_w(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic word_t store_w(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(input int f3, input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic word_t jal_to(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t lui_to(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

`include "tb_program.svh"

    task automatic value_mismatch(input string sig, input word_t got, input word_t exp);
        $display("FAIL t=%0t %s got %h expected %h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic problem(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("test %-16s %s (%0d errors)", name, (errors == err_mark) ? "ok" : "failed",
                 errors - err_mark);
        err_mark = errors;
    endtask

    task automatic handle_request();
        sent++;
        // a credit driven on this edge has not reached the DUT yet
        assert (sent <= credits_given - int'(credit_i))
            else problem("request issued without a credit");
        // same for a response driven on this edge
        assert (outstanding == 0 && !rsp_valid_i)
            else problem("second request while one is outstanding");
        outstanding++;
        rsp_pend  = 1'b1;
        rsp_delay = 1 + $urandom % 3;
        if (!first_req_seen) begin
            first_req_seen = 1'b1;
            assert (req_addr_o == `RESET_PC)
                else value_mismatch("req_addr_o", req_addr_o, `RESET_PC);
            assert (!req_write_o) else problem("first request is a write");
            finish_test("reset");
        end
        if (req_write_o) begin
            rsp_data = '0;
            mem[req_addr_o[9:2]] = req_wdata_o;
            if (store_idx >= STORE_COUNT) begin
                problem("store beyond the expected table");
            end else begin
                // expected stores are laid out one word apart from 0x100
                assert (req_addr_o == 32'h100 + 32'(store_idx * 4))
                    else value_mismatch("req_addr_o", req_addr_o, 32'h100 + 32'(store_idx * 4));
                assert (req_wdata_o == exp_data[store_idx])
                    else value_mismatch("req_wdata_o", req_wdata_o, exp_data[store_idx]);
                store_idx++;
                if (store_idx == 13) finish_test("alu");
                if (store_idx == 15) finish_test("load_store");
                if (store_idx == 20) finish_test("branch_jump");
            end
        end else begin
            rsp_data = mem[req_addr_o[9:2]];
            foreach (skip_pc[k]) begin
                assert (req_addr_o != skip_pc[k]) else problem("fetch of a skipped address");
            end
        end
    endtask

    // memory model driven on the falling edge
    always @(negedge clk) begin
        credit_i    = 1'b0;
        rsp_valid_i = 1'b0;
        if (rst) begin
            assert (!req_valid_o && !halted_o) else problem("request or halt during reset");
        end else begin
            since_reset++;
            if (since_reset <= 10) begin
                assert (!req_valid_o && !halted_o)
                    else problem("request or halt while credits are withheld");
            end else if (credit_gap == 0) begin
                credit_i = 1'b1;
                credits_given++;
                credit_gap = $urandom % 5;
            end else begin
                credit_gap--;
            end
            if (rsp_pend) begin
                rsp_delay--;
                if (rsp_delay == 0) begin
                    rsp_valid_i = 1'b1;
                    rsp_rdata_i = rsp_data;
                    rsp_pend    = 1'b0;
                    outstanding--;
                end
            end
            if (halted_o) begin
                assert (!req_valid_o) else problem("request issued after halt");
            end
            if (req_valid_o) handle_request();
        end
    end

    // about 55 instructions with two transactions of up to 8 cycles each, plus margin
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 2000) begin
            $display("ERROR timeout after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hc3fa90ad));
        rst = 1'b1;
        credit_i = 1'b0;
        rsp_valid_i = 1'b0;
        rsp_rdata_i = '0;
        cycles = 0;
        since_reset = 0;
        errors = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        sent = 0;
        credits_given = 0;
        outstanding = 0;
        store_idx = 0;
        credit_gap = 0;
        rsp_delay = 0;
        rsp_pend = 1'b0;
        first_req_seen = 1'b0;
        rsp_data = '0;
        load_program();
        repeat (5) @(negedge clk);
        rst <= 1'b0;
        wait (halted_o);
        finish_test("credit_rule");
        repeat (20) @(negedge clk); // quiet period after halt
        assert (halted_o) else problem("halt left without a reset");
        assert (store_idx == STORE_COUNT)
            else value_mismatch("store_count", 32'(store_idx), 32'(STORE_COUNT));
        finish_test("illegal_halt");
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
+incdir+tb
hdl/cpu_pkg.sv
hdl/mem_request.sv
hdl/mem_response.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/register_file.sv
hdl/core_sequencer.sv
hdl/cpu_top.sv
tb/tb_cpu_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f verilog.f --top-module tb_cpu_top \
    -o sim_cpu_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cpu_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "no result found in sim.log"
    exit 1
fi
exit 0
